// ==== hb_interp.f ====
common/dsp_types_pkg.sv
common/hb_coeff_pkg.sv
hw/rate_strobe_gen.sv
halfband/hb_product_tree.sv
halfband/halfband_stage.sv
hw/hb_interp_top.sv
tests/hb_interp_properties.sv
tests/tb_hb_interp.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_hb_interp
FILELIST  ?= hb_interp.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?=
PASS_TEXT ?= RESULT: PASS

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# status comes from grep finding the pass line
run: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS) | tee /dev/stderr | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/tb_hb_interp.sv ====
`timescale 1ns/100ps

module tb_hb_interp
    import dsp_types_pkg::*;
    import hb_coeff_pkg::*;
();

    localparam int RESET_CYCLES   = 8;
    localparam int QUIET_SAMPLES  = 24;
    localparam int IMPULSE_TAIL   = 40;
    localparam int DC_SAMPLES     = 48;
    localparam int RANDOM_SAMPLES = 200;
    localparam int RESUME_SAMPLES = 40;
    localparam int FLUSH_SAMPLES  = 16;
    localparam int STIM_SAMPLES   = 2 * QUIET_SAMPLES + 1 + IMPULSE_TAIL + DC_SAMPLES
                                  + RANDOM_SAMPLES + RESUME_SAMPLES + FLUSH_SAMPLES;
    localparam int STIM_CYCLES    = 4 * STIM_SAMPLES + 2 * RESET_CYCLES;
    localparam int CYCLE_LIMIT    = STIM_CYCLES * 3 / 2;
    // product bits that become a 1s17 sum term
    localparam int KEEP_HI = 34;
    localparam int KEEP_LO = 17;
    localparam sample_t HALF_SCALE = 18'sd65535;
    localparam sample_t DC_LEVEL   = 18'sd40000;

    logic    sys_clk;
    logic    reset;
    sample_t in_sample;
    logic    sample_en;
    sample_t out_sample;

    int   seed           = 32'habff5d26;
    int   cycle_count    = 0;
    int   mismatch_count = 0;
    int   other_count    = 0;
    logic expect_zero    = 1'b0;
    logic activity_seen  = 1'b0;

    // reference model state, index 0 is the first stage
    sample_t m_held  [2];
    logic    m_phase [2];
    sample_t m_dly   [2][NUM_TAPS];
    sample_t m_fold  [2][NUM_UNIQUE];
    sample_t m_pair  [2][NUM_UNIQUE/2];
    sample_t m_quad  [2][2];
    sample_t m_total [2];
    sample_t m_out   [2];
    int      m_cnt       = 0;
    logic    m_run       = 1'b0;
    logic    m_half      = 1'b0;
    logic    m_sample    = 1'b0;
    logic    model_valid = 1'b0;

    hb_interp_top #(
        .STAGE1_ID (1),
        .STAGE2_ID (2)
    ) uut (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .in_sample  (in_sample),
        .sample_en  (sample_en),
        .out_sample (out_sample)
    );

    initial begin
        sys_clk = 1'b0;
        forever #5 sys_clk = ~sys_clk;
    end

    function automatic coeff_t stage_coeff(input int s, input int i);
        return (s == 0) ? HB1_COEFFS[i] : HB2_COEFFS[i];
    endfunction

    // one enabled step of a stage, later levels first so each reads the old value
    task automatic step_stage(input int s, input logic step, input logic load,
                              input sample_t din);
        product_t prod;
        sample_t  term [NUM_UNIQUE];
        sample_t  fed;
        if (step) begin
            for (int i = 0; i < NUM_UNIQUE; i++) begin
                prod = product_t'(stage_coeff(s, i)) * product_t'(m_fold[s][i]);
                term[i] = prod[KEEP_HI:KEEP_LO];
            end
            m_out[s]   = m_total[s];
            m_total[s] = m_quad[s][0] + m_quad[s][1];
            for (int q = 0; q < 2; q++) begin
                m_quad[s][q] = m_pair[s][2*q] + m_pair[s][2*q+1];
            end
            for (int p = 0; p < NUM_UNIQUE / 2; p++) begin
                m_pair[s][p] = term[2*p] + term[2*p+1];
            end
            for (int k = 0; k < NUM_UNIQUE - 1; k++) begin
                m_fold[s][k] = m_dly[s][k] + m_dly[s][NUM_TAPS-1-k];
            end
            m_fold[s][NUM_UNIQUE-1] = m_dly[s][NUM_UNIQUE-1];
            for (int t = NUM_TAPS - 1; t > 0; t--) begin
                m_dly[s][t] = m_dly[s][t-1];
            end
            // zero on every other step
            fed = m_phase[s] ? '0 : m_held[s];
            m_dly[s][0] = fed >>> 1;
            m_phase[s] = ~m_phase[s];
        end
        if (load) begin
            m_held[s] = din;
        end
    endtask

    always @(posedge sys_clk) begin : model_step
        sample_t hb1_prev;
        hb1_prev = m_out[0];
        if (reset) begin
            m_held = '{default: '0};
            m_phase = '{default: 1'b0};
            m_dly = '{default: '0};
            m_fold = '{default: '0};
            m_pair = '{default: '0};
            m_quad = '{default: '0};
            m_total = '{default: '0};
            m_out = '{default: '0};
            m_cnt = 0;
        end else begin
            step_stage(0, m_half, m_sample, in_sample);
            step_stage(1, m_run, m_run, hb1_prev);
            m_cnt = m_cnt + 1;
        end
        // enables of the cycle that starts at this edge
        m_run = (m_cnt >= 1);
        m_half = (m_cnt >= 1) && (m_cnt % 2 == 0);
        m_sample = (m_cnt >= 1) && (m_cnt % 4 == 0);
        model_valid = 1'b1;
    end

    always @(negedge sys_clk) begin
        if (model_valid) begin
            assert (out_sample == m_out[1]) else begin
                mismatch_count++;
                $display("CHECK FAILED time=%0t out_sample got=%0d expected=%0d",
                         $time, out_sample, m_out[1]);
            end
            assert (sample_en == m_sample) else begin
                mismatch_count++;
                $display("CHECK FAILED time=%0t sample_en got=%0b expected=%0b",
                         $time, sample_en, m_sample);
            end
            if (expect_zero) begin
                assert (out_sample == '0) else begin
                    mismatch_count++;
                    $display("CHECK FAILED time=%0t out_sample got=%0d expected=0",
                             $time, out_sample);
                end
            end
            if (out_sample != '0) begin
                activity_seen = 1'b1;
            end
        end
    end

    always @(posedge sys_clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: stimulus did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // waits for the next sample_en cycle and presents the value there
    task automatic present_sample(input sample_t value);
        @(negedge sys_clk);
        while (!sample_en) begin
            @(negedge sys_clk);
        end
        in_sample = value;
    endtask

    task automatic send_level(input sample_t value, input int count);
        for (int n = 0; n < count; n++) begin
            present_sample(value);
        end
    endtask

    task automatic send_random(input int count);
        int r;
        for (int n = 0; n < count; n++) begin
            r = $random(seed);
            present_sample(sample_t'($signed(r[16:0])));
        end
    endtask

    task automatic hold_reset(input int cycles);
        reset = 1'b1;
        repeat (cycles) @(negedge sys_clk);
        reset = 1'b0;
    endtask

    task automatic confirm_activity(input string section);
        @(posedge sys_clk);
        assert (activity_seen) else begin
            other_count++;
            $display("the %s section produced no output at all", section);
        end
        activity_seen = 1'b0;
    endtask

    initial begin
        in_sample = '0;
        hold_reset(RESET_CYCLES);
        expect_zero <= 1'b1;
        send_level('0, QUIET_SAMPLES);
        expect_zero <= 1'b0;
        present_sample(HALF_SCALE);
        send_level('0, IMPULSE_TAIL);
        confirm_activity("impulse");
        send_level(DC_LEVEL, DC_SAMPLES);
        confirm_activity("dc");
        send_random(RANDOM_SAMPLES);
        // reset while the whole pipeline is full
        @(negedge sys_clk);
        hold_reset(RESET_CYCLES);
        // only output after the reset counts
        activity_seen = 1'b0;
        send_random(RESUME_SAMPLES);
        confirm_activity("post-reset");
        send_level('0, FLUSH_SAMPLES);
        expect_zero <= 1'b1;
        send_level('0, QUIET_SAMPLES);
        @(posedge sys_clk);
        $display("errors: %0d value mismatches, %0d property failures, %0d other failures",
                 mismatch_count, uut.u_props.fail_count, other_count);
        if (mismatch_count == 0 && other_count == 0 && uut.u_props.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tests/hb_interp_properties.sv ====
`timescale 1ns/100ps

module hb_interp_properties
    import dsp_types_pkg::*;
(
    input logic    sys_clk,
    input logic    reset,
    input logic    sample_en,
    input logic    half_en,
    input logic    run_en,
    input sample_t out_sample
);

    // number of property failures
    int fail_count = 0;

    // synchronous reset clears enables and the output register
    a_reset_clears: assert property (@(posedge sys_clk)
        reset |=> !run_en && !half_en && !sample_en && out_sample == '0)
        else begin
            $error("reset did not clear the enables and out_sample");
            fail_count++;
        end

    a_run_starts: assert property (@(posedge sys_clk) disable iff (reset)
        $fell(reset) |=> run_en)
        else begin
            $error("run_en not high on the first cycle after reset");
            fail_count++;
        end

    a_run_holds: assert property (@(posedge sys_clk) disable iff (reset)
        $past(run_en) |-> run_en)
        else begin
            $error("run_en dropped while out of reset");
            fail_count++;
        end

    // half_en toggles, one cycle high and one low
    a_half_gap: assert property (@(posedge sys_clk) disable iff (reset)
        half_en |-> run_en && !$past(half_en))
        else begin
            $error("half_en high on two cycles in a row");
            fail_count++;
        end

    a_half_period: assert property (@(posedge sys_clk) disable iff (reset)
        $past(half_en, 2) |-> half_en)
        else begin
            $error("half_en missed its period of two");
            fail_count++;
        end

    // sample_en sits on a half_en pulse, three quiet cycles before it
    a_sample_gap: assert property (@(posedge sys_clk) disable iff (reset)
        sample_en |-> half_en && !$past(sample_en, 1) && !$past(sample_en, 2)
                      && !$past(sample_en, 3))
        else begin
            $error("sample_en closer than four cycles");
            fail_count++;
        end

    a_sample_period: assert property (@(posedge sys_clk) disable iff (reset)
        $past(sample_en, 4) |-> sample_en)
        else begin
            $error("sample_en missed its period of four");
            fail_count++;
        end

endmodule

bind hb_interp_top hb_interp_properties u_props (
    .sys_clk    (sys_clk),
    .reset      (reset),
    .sample_en  (sample_en),
    .half_en    (half_en),
    .run_en     (run_en),
    .out_sample (out_sample)
);

// ==== hw/hb_interp_top.sv ====
`timescale 1ns/100ps

module hb_interp_top
    import dsp_types_pkg::*;
#(
    parameter int STAGE1_ID = 1,
    parameter int STAGE2_ID = 2
) (
    input  logic    sys_clk,
    input  logic    reset,
    input  sample_t in_sample,
    output logic    sample_en,
    output sample_t out_sample
);

    logic    half_en;
    logic    run_en;
    sample_t hb1_out;

    rate_strobe_gen u_strobe (
        .sys_clk   (sys_clk),
        .reset     (reset),
        .sample_en (sample_en),
        .half_en   (half_en),
        .run_en    (run_en)
    );

    // first 2x, input at quarter rate, steps at half rate
    halfband_stage #(
        .STAGE_ID (STAGE1_ID)
    ) u_hb1 (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .step_en    (half_en),
        .load_en    (sample_en),
        .in_sample  (in_sample),
        .out_sample (hb1_out)
    );

    // second 2x, picks up stage 1 every cycle and steps every cycle
    halfband_stage #(
        .STAGE_ID (STAGE2_ID)
    ) u_hb2 (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .step_en    (run_en),
        .load_en    (run_en),
        .in_sample  (hb1_out),
        .out_sample (out_sample)
    );

endmodule

// ==== halfband/halfband_stage.sv ====
`timescale 1ns/100ps

module halfband_stage
    import dsp_types_pkg::*;
    import hb_coeff_pkg::*;
#(
    parameter int STAGE_ID = 1
) (
    input  logic    sys_clk,
    input  logic    reset,
    input  logic    step_en,
    input  logic    load_en,
    input  sample_t in_sample,
    output sample_t out_sample
);

    // index of the unpaired middle tap
    localparam int CENTER = NUM_UNIQUE - 1;

    sample_t held_sample;
    logic    stuff_phase;
    sample_t stuffed;
    sample_t halved;
    sample_t delay_line  [NUM_TAPS];
    sample_t folded_taps [NUM_UNIQUE];

    // latest input sample, refreshed on load_en
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            held_sample <= '0;
        end else if (load_en) begin
            held_sample <= in_sample;
        end
    end

    // even phase passes the sample, odd phase inserts a zero
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            stuff_phase <= 1'b0;
        end else if (step_en) begin
            stuff_phase <= ~stuff_phase;
        end
    end

    assign stuffed = stuff_phase ? '0 : held_sample;

    // 1s17 to 2s16 so the pre-add cannot overflow
    assign halved = stuffed >>> 1;

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            delay_line <= '{default: '0};
        end else if (step_en) begin
            delay_line[0] <= halved;
            for (int t = 1; t < NUM_TAPS; t++) begin
                delay_line[t] <= delay_line[t-1];
            end
        end
    end

    // symmetric taps share a coefficient, so add them first
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            folded_taps <= '{default: '0};
        end else if (step_en) begin
            for (int k = 0; k < CENTER; k++) begin
                folded_taps[k] <= delay_line[k] + delay_line[NUM_TAPS-1-k];
            end
            folded_taps[CENTER] <= delay_line[CENTER];
        end
    end

    hb_product_tree #(
        .STAGE_ID (STAGE_ID)
    ) u_tree (
        .sys_clk     (sys_clk),
        .reset       (reset),
        .step_en     (step_en),
        .folded_taps (folded_taps),
        .tree_sum    (out_sample)
    );

endmodule

// ==== halfband/hb_product_tree.sv ====
`timescale 1ns/100ps

module hb_product_tree
    import dsp_types_pkg::*;
    import hb_coeff_pkg::*;
#(
    parameter int STAGE_ID = 1
) (
    input  logic    sys_clk,
    input  logic    reset,
    input  logic    step_en,
    input  sample_t folded_taps [NUM_UNIQUE],
    output sample_t tree_sum
);

    localparam int NUM_PAIRS = NUM_UNIQUE / 2;
    localparam int NUM_QUADS = NUM_UNIQUE / 4;

    product_t products  [NUM_UNIQUE];
    sample_t  scaled    [NUM_UNIQUE];
    sample_t  pair_sum  [NUM_PAIRS];
    sample_t  quad_sum  [NUM_QUADS];
    sample_t  total_sum;

    // 0s18 coefficient times 2s16 folded tap gives 2s34
    for (genvar i = 0; i < NUM_UNIQUE; i++) begin : g_mult
        localparam coeff_t COEFF = (STAGE_ID == 2) ? HB2_COEFFS[i] : HB1_COEFFS[i];

        assign products[i] = COEFF * folded_taps[i];
        // drop the redundant sign bit and the low half, leaves 1s17
        assign scaled[i] = products[i][PRODUCT_KEEP_MSB:PRODUCT_KEEP_LSB];
    end

    // adder tree, one register per level, sums wrap
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            pair_sum  <= '{default: '0};
            quad_sum  <= '{default: '0};
            total_sum <= '0;
            tree_sum  <= '0;
        end else if (step_en) begin
            for (int p = 0; p < NUM_PAIRS; p++) begin
                pair_sum[p] <= scaled[2*p] + scaled[2*p+1];
            end
            for (int q = 0; q < NUM_QUADS; q++) begin
                quad_sum[q] <= pair_sum[2*q] + pair_sum[2*q+1];
            end
            total_sum <= quad_sum[0] + quad_sum[1];
            // output register of the stage
            tree_sum  <= total_sum;
        end
    end

endmodule

// ==== hw/rate_strobe_gen.sv ====
`timescale 1ns/100ps

module rate_strobe_gen (
    input  logic sys_clk,
    input  logic reset,
    output logic sample_en,
    output logic half_en,
    output logic run_en
);

    // quarter-cycle position of the current sys_clk cycle
    logic [1:0] phase_cnt;

    // set on the first cycle after reset, stays set
    logic run_flag;

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            run_flag <= 1'b0;
        end else begin
            run_flag <= 1'b1;
        end
    end

    // counter only advances once the chain is running
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            phase_cnt <= 2'd0;
        end else if (run_flag) begin
            phase_cnt <= phase_cnt + 2'd1;
        end
    end

    // full rate step for the second stage
    assign run_en = run_flag;

    // odd phases, 2nd cycle after reset onwards
    assign half_en = run_flag && phase_cnt[0];

    // last phase of four, lines up with a half_en pulse
    assign sample_en = run_flag && (phase_cnt == 2'd3);

endmodule

// ==== common/hb_coeff_pkg.sv ====
package hb_coeff_pkg;

    import dsp_types_pkg::*;

    // filter length
    localparam int NUM_TAPS = 15;

    // seven folded pairs plus the center tap
    localparam int NUM_UNIQUE = (NUM_TAPS + 1) / 2;

    // first stage, runs at half rate
    // entry i weights taps i and NUM_TAPS-1-i, last entry is the center
    localparam coeff_t HB1_COEFFS [NUM_UNIQUE] = '{
        -18'sd348,
        18'sd0,
        18'sd3274,
        18'sd0,
        -18'sd15925,
        18'sd0,
        18'sd78535,
        18'sd131071
    };

    // second stage, runs on every enabled cycle
    // slightly wider transition band than the first stage
    localparam coeff_t HB2_COEFFS [NUM_UNIQUE] = '{
        -18'sd322,
        18'sd0,
        18'sd3144,
        18'sd0,
        -18'sd15695,
        18'sd0,
        18'sd78408,
        18'sd131071
    };

endpackage

// ==== common/dsp_types_pkg.sv ====
package dsp_types_pkg;

    // datapath widths
    localparam int SAMPLE_W  = 18;
    localparam int COEFF_W   = 18;
    localparam int PRODUCT_W = SAMPLE_W + COEFF_W;

    // product bits kept after the multiply
    // 2s34 product down to a 1s17 sum term
    localparam int PRODUCT_KEEP_MSB = PRODUCT_W - 2;
    localparam int PRODUCT_KEEP_LSB = COEFF_W - 1;

    // samples at every datapath port
    // 1s17 at the chain edges, 2s16 inside the delay line
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // filter coefficient, 0s18
    typedef logic signed [COEFF_W-1:0] coeff_t;

    // full multiplier result, 2s34
    typedef logic signed [PRODUCT_W-1:0] product_t;

endpackage
